// ==== verilog/cpu_macros.svh ====
// widths and encodings of the core; only lw, sw, sub, xori and amul are decoded
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define WORD_W      32
`define REG_IDX_W   5
`define IMEM_DEPTH  64
`define DMEM_DEPTH  64
`define IMEM_ADDR_W 6
`define DMEM_ADDR_W 6
`define ALU_OP_W    2

`define OP_LW       6'b100011
`define OP_SW       6'b101011
`define OP_RTYPE    6'b000000
`define OP_XORI     6'b001110

`define FN_SUB      6'b100010
`define FN_AMUL     6'b111111 // rs * rt + rt

`define ALU_ADD     2'b00
`define ALU_SUB     2'b01
`define ALU_XOR     2'b10
`define ALU_AMUL    2'b11

`endif

// ==== verilog/cpuPkg.sv ====
// shared vector types of the core; widths come from cpu_macros.svh
`include "cpu_macros.svh"

package cpuPkg;

    // data words and instruction words share one width
    typedef logic [`WORD_W-1:0] word_t;

    typedef logic [`REG_IDX_W-1:0] regIdx_t;

    // memories are word addressed, no byte lanes
    typedef logic [`IMEM_ADDR_W-1:0] imemAddr_t;
    typedef logic [`DMEM_ADDR_W-1:0] dmemAddr_t;

    typedef logic [`ALU_OP_W-1:0] aluOp_t;

endpackage

// ==== verilog/pipeLinks.sv ====
// stage bundles of the pipeline; no handshake, every field is sampled each clock
`include "cpu_macros.svh"

interface execLink;
    logic                   valid;
    logic [`ALU_OP_W-1:0]   aluOp;
    logic [`WORD_W-1:0]     opA;     // rs value from the register file
    logic [`WORD_W-1:0]     opB;     // rt value, also the store data source
    logic [`REG_IDX_W-1:0]  rsIdx;
    logic [`REG_IDX_W-1:0]  rtIdx;
    logic                   useImm;
    logic [`WORD_W-1:0]     imm;     // already sign extended
    logic [`REG_IDX_W-1:0]  destIdx;
    logic                   writesReg;
    logic                   isLoad;
    logic                   isStore;

    modport sender (output valid, aluOp, opA, opB, rsIdx, rtIdx, useImm, imm,
                    destIdx, writesReg, isLoad, isStore);
    modport receiver (input valid, aluOp, opA, opB, rsIdx, rtIdx, useImm, imm,
                      destIdx, writesReg, isLoad, isStore);
endinterface

interface memLink;
    logic                   valid;
    logic [`WORD_W-1:0]     aluResult;
    logic [`WORD_W-1:0]     storeData;
    logic [`REG_IDX_W-1:0]  destIdx;
    logic                   writesReg;
    logic                   isLoad;
    logic                   isStore;

    // forwarding paths back into execute
    logic [`REG_IDX_W-1:0]  memDest;
    logic                   memWrites;
    logic [`WORD_W-1:0]     memValue;
    logic [`REG_IDX_W-1:0]  wbDest;
    logic                   wbWrites;
    logic [`WORD_W-1:0]     wbValue;

    modport sender (output valid, aluResult, storeData, destIdx, writesReg, isLoad, isStore);
    // memory stage consumes the bundle and sources both bypass buses
    modport receiver (input valid, aluResult, storeData, destIdx, writesReg, isLoad, isStore,
                      output memDest, memWrites, memValue, wbDest, wbWrites, wbValue);
    modport bypass (input memDest, memWrites, memValue, wbDest, wbWrites, wbValue);
endinterface

// ==== verilog/fetchUnit.sv ====
// program is loaded only while run is low; pc restarts at word 0 when run rises
`include "cpu_macros.svh"

module fetchUnit import cpuPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    input  logic      loadEn,
    input  imemAddr_t loadAddr,
    input  word_t     loadInstr,
    output word_t     fetchInstr,
    output logic      fetchValid
);

    word_t     imem [`IMEM_DEPTH];
    imemAddr_t pc;

    // load port, contents survive reset
    always_ff @(posedge clk) begin
        if (loadEn) begin
            imem[loadAddr] <= loadInstr;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc         <= '0;
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= run;
            if (run) begin
                pc <= pc + 1'b1; // wraps past the last word
            end else begin
                pc <= '0;
            end
        end
    end

    // fetch register
    always_ff @(posedge clk) begin
        fetchInstr <= imem[pc];
    end

endmodule

// ==== verilog/regFile.sv ====
// 32 registers, register 0 hardwired to zero, same-cycle write is visible on reads
module regFile import cpuPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  regIdx_t rdIdxA,
    input  regIdx_t rdIdxB,
    output word_t   rdDataA,
    output word_t   rdDataB,
    input  logic    wrEn,
    input  regIdx_t wrIdx,
    input  word_t   wrData
);

    word_t regs [32];

    function automatic word_t readPort(input regIdx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wrEn && idx == wrIdx) begin
            return wrData; // write-through
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrIdx != '0) begin
            regs[wrIdx] <= wrData;
        end
    end

    // reads also follow the write port and the register contents
    always_comb begin
        rdDataA = readPort(rdIdxA);
        rdDataB = readPort(rdIdxB);
    end

endmodule

// ==== verilog/decodeStage.sv ====
// unknown opcodes, unknown funct codes and the all-zero word decode as bubbles
`include "cpu_macros.svh"

module decodeStage import cpuPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  word_t   fetchInstr,
    input  logic    fetchValid,
    execLink.sender execLink,
    input  logic    wrEn,
    input  regIdx_t wrIdx,
    input  word_t   wrData
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regIdx_t    rsIdx;
    regIdx_t    rtIdx;
    regIdx_t    rdIdx;
    word_t      rsData;
    word_t      rtData;
    logic       known;
    logic       isRtype;
    logic       useImm;
    logic       writesReg;
    logic       isLoad;
    logic       isStore;
    aluOp_t     aluOp;

    assign opcode = fetchInstr[31:26];
    assign funct  = fetchInstr[5:0];
    assign rsIdx  = fetchInstr[25:21];
    assign rtIdx  = fetchInstr[20:16];
    assign rdIdx  = fetchInstr[15:11];

    regFile rf (
        .clk     (clk),
        .reset   (reset),
        .rdIdxA  (rsIdx),
        .rdIdxB  (rtIdx),
        .rdDataA (rsData),
        .rdDataB (rtData),
        .wrEn    (wrEn),
        .wrIdx   (wrIdx),
        .wrData  (wrData)
    );

    always_comb begin
        known   = 1'b1;
        isRtype = 1'b0;
        useImm  = 1'b1;
        isLoad  = 1'b0;
        isStore = 1'b0;
        aluOp   = `ALU_ADD; // address calculation by default
        case (opcode)
            `OP_LW:   isLoad = 1'b1;
            `OP_SW:   isStore = 1'b1;
            `OP_XORI: aluOp = `ALU_XOR;
            `OP_RTYPE: begin
                isRtype = 1'b1;
                useImm  = 1'b0;
                case (funct)
                    `FN_SUB:  aluOp = `ALU_SUB;
                    `FN_AMUL: aluOp = `ALU_AMUL;
                    default:  known = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase
        writesReg = fetchValid && known && !isStore;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            execLink.valid     <= 1'b0;
            execLink.writesReg <= 1'b0;
            execLink.isLoad    <= 1'b0;
            execLink.isStore   <= 1'b0;
        end else begin
            execLink.valid     <= fetchValid && known;
            execLink.writesReg <= writesReg;
            execLink.isLoad    <= fetchValid && known && isLoad;
            execLink.isStore   <= fetchValid && known && isStore;
        end
    end

    always_ff @(posedge clk) begin
        execLink.aluOp   <= aluOp;
        execLink.opA     <= rsData;
        execLink.opB     <= rtData;
        execLink.rsIdx   <= rsIdx;
        execLink.rtIdx   <= rtIdx;
        execLink.useImm  <= useImm;
        execLink.imm     <= {{16{fetchInstr[15]}}, fetchInstr[15:0]};
        execLink.destIdx <= isRtype ? rdIdx : rtIdx; // rd for R-type, rt otherwise
    end

endmodule

// ==== verilog/executeStage.sv ====
// forwarding covers ALU results only from memory; a load result needs one slot of distance
`include "cpu_macros.svh"

module executeStage import cpuPkg::*; (
    input  logic      clk,
    input  logic      reset,
    execLink.receiver execLink,
    memLink.sender    memLink,
    memLink.bypass    bypass
);

    word_t fwdA;
    word_t fwdB;
    word_t aluB;
    word_t aluResult;

    // memory-stage value wins over writeback, register 0 is never forwarded
    function automatic word_t forward(input regIdx_t idx, input word_t regValue);
        if (idx == '0) begin
            return regValue;
        end else if (bypass.memWrites && bypass.memDest == idx) begin
            return bypass.memValue;
        end else if (bypass.wbWrites && bypass.wbDest == idx) begin
            return bypass.wbValue;
        end
        return regValue;
    endfunction

    // bypass buses are read inside forward
    always_comb begin
        fwdA = forward(execLink.rsIdx, execLink.opA);
        fwdB = forward(execLink.rtIdx, execLink.opB);
    end

    assign aluB = execLink.useImm ? execLink.imm : fwdB;

    always_comb begin
        case (execLink.aluOp)
            `ALU_ADD: aluResult = fwdA + aluB;
            `ALU_SUB: aluResult = fwdA - aluB;
            `ALU_XOR: aluResult = fwdA ^ aluB;
            default:  aluResult = fwdA * aluB + aluB; // amul, low word kept
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            memLink.valid     <= 1'b0;
            memLink.writesReg <= 1'b0;
            memLink.isLoad    <= 1'b0;
            memLink.isStore   <= 1'b0;
        end else begin
            memLink.valid     <= execLink.valid;
            memLink.writesReg <= execLink.writesReg;
            memLink.isLoad    <= execLink.isLoad;
            memLink.isStore   <= execLink.isStore;
        end
    end

    always_ff @(posedge clk) begin
        memLink.aluResult <= aluResult;
        memLink.storeData <= fwdB; // forwarded rt for sw
        memLink.destIdx   <= execLink.destIdx;
    end

endmodule

// ==== verilog/memStage.sv ====
// data memory has no reset; addresses use the low bits of the ALU result only
`include "cpu_macros.svh"

module memStage import cpuPkg::*; (
    input  logic      clk,
    input  logic      reset,
    memLink.receiver  memLink,
    output logic      storeValid,
    output dmemAddr_t storeAddr,
    output word_t     storeData,
    output logic      retireValid,
    output regIdx_t   retireReg,
    output word_t     retireData,
    output logic      wrEn,
    output regIdx_t   wrIdx,
    output word_t     wrData
);

    word_t     dmem [`DMEM_DEPTH];
    dmemAddr_t addr;
    word_t     loadData;
    logic      wbValid;
    logic      wbWrites;
    regIdx_t   wbDest;
    word_t     wbValue;

    assign addr     = memLink.aluResult[`DMEM_ADDR_W-1:0];
    assign loadData = dmem[addr];

    assign storeValid = memLink.valid && memLink.isStore;
    assign storeAddr  = addr;
    assign storeData  = memLink.storeData;

    always_ff @(posedge clk) begin
        if (storeValid) begin
            dmem[addr] <= memLink.storeData;
        end
    end

    // writeback register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wbValid  <= 1'b0;
            wbWrites <= 1'b0;
        end else begin
            wbValid  <= memLink.valid;
            wbWrites <= memLink.valid && memLink.writesReg;
        end
    end

    always_ff @(posedge clk) begin
        wbDest  <= memLink.destIdx;
        wbValue <= memLink.isLoad ? loadData : memLink.aluResult;
    end

    // load data is not ready here, so loads stay off this path
    assign memLink.memDest   = memLink.destIdx;
    assign memLink.memWrites = memLink.valid && memLink.writesReg && !memLink.isLoad;
    assign memLink.memValue  = memLink.aluResult;

    assign memLink.wbDest   = wbDest;
    assign memLink.wbWrites = wbValid && wbWrites;
    assign memLink.wbValue  = wbValue;

    assign retireValid = wbValid && wbWrites && wbDest != '0;
    assign retireReg   = wbDest;
    assign retireData  = wbValue;

    assign wrEn   = retireValid;
    assign wrIdx  = wbDest;
    assign wrData = wbValue;

endmodule

// ==== verilog/cpuTop.sv ====
// five-stage core without load-use interlock; software must space a load and its user
module cpuTop import cpuPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    input  logic      loadEn,
    input  imemAddr_t loadAddr,
    input  word_t     loadInstr,
    output logic      retireValid,
    output regIdx_t   retireReg,
    output word_t     retireData,
    output logic      storeValid,
    output dmemAddr_t storeAddr,
    output word_t     storeData
);

    word_t   fetchInstr;
    logic    fetchValid;
    logic    wrEn;
    regIdx_t wrIdx;
    word_t   wrData;

    execLink exLink ();
    memLink  mLink ();

    fetchUnit fetch (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .loadEn     (loadEn),
        .loadAddr   (loadAddr),
        .loadInstr  (loadInstr),
        .fetchInstr (fetchInstr),
        .fetchValid (fetchValid)
    );

    decodeStage decode (
        .clk        (clk),
        .reset      (reset),
        .fetchInstr (fetchInstr),
        .fetchValid (fetchValid),
        .execLink   (exLink.sender),
        .wrEn       (wrEn),
        .wrIdx      (wrIdx),
        .wrData     (wrData)
    );

    executeStage execute (
        .clk      (clk),
        .reset    (reset),
        .execLink (exLink.receiver),
        .memLink  (mLink.sender),
        .bypass   (mLink.bypass)
    );

    memStage mem (
        .clk         (clk),
        .reset       (reset),
        .memLink     (mLink.receiver),
        .storeValid  (storeValid),
        .storeAddr   (storeAddr),
        .storeData   (storeData),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retireData  (retireData),
        .wrEn        (wrEn),
        .wrIdx       (wrIdx),
        .wrData      (wrData)
    );

endmodule

// ==== verification/cpuTb.sv ====
// needs the project root as run directory to find the trace; loads must be spaced from their users
`include "cpu_macros.svh"

module cpuTb import cpuPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int DRAIN_CYCLES   = 20;

    logic      clk;
    logic      reset;
    logic      run;
    logic      loadEn;
    imemAddr_t loadAddr;
    word_t     loadInstr;
    logic      retireValid;
    regIdx_t   retireReg;
    word_t     retireData;
    logic      storeValid;
    dmemAddr_t storeAddr;
    word_t     storeData;

    word_t     progWords [$];
    regIdx_t   expRetReg [$];
    word_t     expRetData [$];
    dmemAddr_t expStAddr [$];
    word_t     expStData [$];

    cpuTop DUT (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .loadEn      (loadEn),
        .loadAddr    (loadAddr),
        .loadInstr   (loadInstr),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retireData  (retireData),
        .storeValid  (storeValid),
        .storeAddr   (storeAddr),
        .storeData   (storeData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // I <word>, R <reg> <value>, S <addr> <data>, # starts a comment line
    task automatic readTrace();
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  kind;
        logic [31:0] first;
        logic [31:0] second;
        fd = $fopen("verification/program_trace.txt", "r");
        if (fd == 0) begin
            stopWithFailure("the trace file verification/program_trace.txt could not be opened");
        end
        while ($fgets(line, fd) != 0) begin
            kind = line.getc(0);
            if (line.len() < 3 || kind == "#") begin
                continue;
            end
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", first, second);
            if (fields < 1 || (kind != "I" && fields < 2)) begin
                stopWithFailure({"the trace holds a malformed line: ", line});
            end
            case (kind)
                "I": progWords.push_back(first);
                "R": begin
                    expRetReg.push_back(first[`REG_IDX_W-1:0]);
                    expRetData.push_back(second);
                end
                "S": begin
                    expStAddr.push_back(first[`DMEM_ADDR_W-1:0]);
                    expStData.push_back(second);
                end
                default: stopWithFailure({"the trace holds an unknown line kind: ", line});
            endcase
        end
        $fclose(fd);
        if (progWords.size() > `IMEM_DEPTH) begin
            stopWithFailure("the trace program does not fit into instruction memory");
        end
    endtask

    // every word is written so no stale contents get fetched after a wrap
    task automatic loadProgram();
        for (int addr = 0; addr < `IMEM_DEPTH; addr++) begin
            @(posedge clk);
            loadEn    <= 1'b1;
            loadAddr  <= imemAddr_t'(addr);
            loadInstr <= (addr < progWords.size()) ? progWords[addr] : '0;
        end
        @(posedge clk);
        loadEn <= 1'b0;
    endtask

    task automatic listMissing(input int waited);
        $display("timeout after %0d cycles: %0d retire and %0d store events never arrived",
                 waited, expRetReg.size(), expStAddr.size());
        foreach (expRetReg[i]) begin
            $display("  retire of r%0d = %h never arrived", expRetReg[i], expRetData[i]);
        end
        foreach (expStAddr[i]) begin
            $display("  store to word %0d = %h never arrived", expStAddr[i], expStData[i]);
        end
    endtask

    // outputs are sampled at the edge, before the stage registers update
    always @(posedge clk) begin
        if (reset && retireValid) begin
            assert (expRetReg.size() != 0)
            else stopWithFailure($sformatf("an extra retire of r%0d = %h came at %0t",
                                           retireReg, retireData, $time));
            assert (retireReg == expRetReg[0] && retireData == expRetData[0])
            else stopWithFailure($sformatf(
                "** Error at %0t: retire expected r%0d = %h, observed r%0d = %h",
                $time, expRetReg[0], expRetData[0], retireReg, retireData));
            void'(expRetReg.pop_front());
            void'(expRetData.pop_front());
        end
        if (reset && storeValid) begin
            assert (expStAddr.size() != 0)
            else stopWithFailure($sformatf("an extra store to word %0d = %h came at %0t",
                                           storeAddr, storeData, $time));
            assert (storeAddr == expStAddr[0] && storeData == expStData[0])
            else stopWithFailure($sformatf(
                "** Error at %0t: store expected [%0d] = %h, observed [%0d] = %h",
                $time, expStAddr[0], expStData[0], storeAddr, storeData));
            void'(expStAddr.pop_front());
            void'(expStData.pop_front());
        end
    end

    initial begin
        int cycles;
        reset     = 1'b0;
        run       = 1'b0;
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadInstr = '0;
        $timeformat(-9, 0, " ns", 0);
        readTrace();
        repeat (5) @(posedge clk);
        reset <= 1'b1;
        loadProgram();
        @(posedge clk);
        run <= 1'b1; // pc starts at word 0
        cycles = 0;
        while ((expRetReg.size() != 0 || expStAddr.size() != 0) && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (expRetReg.size() != 0 || expStAddr.size() != 0) begin
            listMissing(cycles);
        end else begin
            for (int n = 0; n < DRAIN_CYCLES; n++) begin
                @(posedge clk); // extra events are caught by the monitor
            end
        end
        if (expRetReg.size() == 0 && expStAddr.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "expected events are missing");
        end
    end

endmodule

// ==== verification/program_trace.txt ====
# I <instruction word, hex> | R <register, hex> <value, hex> | S <word address, hex> <data, hex>
# I lines load from word 0 upward; R and S events are expected in the order listed
I 38010005  # xori r1, r0, 5
I 3802FFFD  # xori r2, r0, -3
I 00221822  # sub  r3, r1, r2      r2 from memory, r1 from writeback
I 0061203F  # amul r4, r3, r1      r3 from memory, r1 through the register file
I 38001234  # xori r0, r0, 0x1234  no retire
I 00802822  # sub  r5, r4, r0      r0 still reads zero
I 00000000  # bubble
I AC250003  # sw   r5, 3(r1)       address 8
I 38060007  # xori r6, r0, 7
I 8C47000B  # lw   r7, 11(r2)      address 8
I 38080001  # xori r8, r0, 1       spacer after the load
I 00E84822  # sub  r9, r7, r8
I 00000000  # bubble
I 0126503F  # amul r10, r9, r6
I FC000000  # unknown opcode, bubble
I ACCAFFFF  # sw   r10, -1(r6)     address 6
I 394B00FF  # xori r11, r10, 0xff
R 01 00000005
R 02 fffffffd
R 03 00000008
R 04 0000002d
R 05 0000002d
R 06 00000007
R 07 0000002d
R 08 00000001
R 09 0000002c
R 0a 0000013b
R 0b 000001c4
S 08 0000002d
S 06 0000013b

// ==== flist.f ====
+incdir+verilog
verilog/cpuPkg.sv
verilog/pipeLinks.sv
verilog/fetchUnit.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memStage.sv
verilog/cpuTop.sv
verification/cpuTb.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = cpuTb
FLIST      = flist.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '>>> PASS' $(LOG); then echo "simulation passed"; \
	else echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
